// ==== Bender.yml ====
package:
  name: axi_write_master

sources:
  - design/axi_wm_pkg.sv
  - design/wstream_fifo.sv
  - design/burst_planner.sv
  - design/wdata_channel.sv
  - design/awaddr_channel.sv
  - design/bresp_tracker.sv
  - design/axi_write_master.sv
  - target: test
    files:
      - tb/tb_axi_write_master.sv

// ==== design/awaddr_channel.sv ====
// AXI4 write address channel, one AW per burst once that burst's first beat is on W
`timescale 1ns/1ps
`default_nettype none

module awaddr_channel #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    start,
  input  axi_wm_pkg::burst_plan_t plan,
  input  logic                    first_beat_pulse,
  input  logic                    stall_aw,
  output axi_wm_pkg::aw_req_t     m_axi_aw,
  output logic                    m_axi_awvalid,
  input  logic                    m_axi_awready,
  output logic                    aw_accepted
);
  import axi_wm_pkg::*;

  // W may run a whole transfer ahead of AW while responses are held back
  localparam int PEND_WIDTH = TXN_CNT_WIDTH + 1;

  logic                     awxfer;
  logic                     aw_avail;
  logic [PEND_WIDTH-1:0]    pend_cnt;   // First beats still waiting for an address
  logic [ADDR_WIDTH-1:0]    addr_r;
  logic [TXN_CNT_WIDTH-1:0] aw_to_go;

  if (MAX_OUTSTANDING < 1) begin : g_bad_outstanding
    $error("MAX_OUTSTANDING must be at least 1");
  end

  assign awxfer      = m_axi_awvalid & m_axi_awready;
  assign aw_accepted = awxfer;
  // Fresh pulse counts straight away, saves a cycle on the rise of awvalid
  assign aw_avail    = (pend_cnt != '0) | first_beat_pulse;

  assign m_axi_aw.awaddr = addr_r;
  assign m_axi_aw.awlen  = (aw_to_go == '0) ? plan.final_len
                                            : BURST_LEN_WIDTH'(BURST_LEN - 1);

  ////////////////////////////////////////////////////////////
  // Valid and pending first beats
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
      pend_cnt      <= '0;
    end else begin
      if (m_axi_awvalid) begin
        m_axi_awvalid <= ~m_axi_awready;
      end else begin
        m_axi_awvalid <= aw_avail & ~stall_aw;
      end
      if (first_beat_pulse && !awxfer) begin
        pend_cnt <= pend_cnt + 1'b1;
      end else if (awxfer && !first_beat_pulse) begin
        pend_cnt <= pend_cnt - 1'b1;
      end
    end
  end

  // Burst counter, the last burst takes final_len
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_to_go <= '0;
    end else if (start) begin
      aw_to_go <= plan.last_txn_index;
    end else if (awxfer) begin
      aw_to_go <= aw_to_go - 1'b1;
    end
  end

  // Address steps one 1 KiB window per burst
  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r <= plan.base_addr;
    end else if (awxfer) begin
      addr_r <= addr_r + ADDR_WIDTH'(BURST_BYTES);
    end
  end

  a_aw_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_aw));

endmodule

`default_nettype wire

// ==== design/axi_wm_pkg.sv ====
// AXI4 write master package with bus widths, AXI burst limits and shared bus structs
`default_nettype none

package axi_wm_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int XFER_SIZE_WIDTH = 16;

  ////////////////////////////////////////////////////////////
  // AXI4 burst limits
  ////////////////////////////////////////////////////////////
  localparam int AXI_MAX_BURST_LEN   = 256;
  localparam int AXI_MAX_BURST_BYTES = 4096;

  // Full burst is the tighter of the beat limit and the byte limit in words
  localparam int BURST_LEN =
    (AXI_MAX_BURST_BYTES / STRB_WIDTH < AXI_MAX_BURST_LEN) ?
    AXI_MAX_BURST_BYTES / STRB_WIDTH : AXI_MAX_BURST_LEN;
  localparam int BURST_LEN_WIDTH = $clog2(BURST_LEN);
  // Address step between bursts, also the alignment of the start address
  localparam int BURST_BYTES     = BURST_LEN * STRB_WIDTH;
  // Enough bits to index every burst of the largest transfer
  localparam int TXN_CNT_WIDTH   = XFER_SIZE_WIDTH - $clog2(STRB_WIDTH) - BURST_LEN_WIDTH;

  ////////////////////////////////////////////////////////////
  // Shared structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      base_addr;
    logic [TXN_CNT_WIDTH-1:0]   last_txn_index;  // Burst count minus one
    logic [BURST_LEN_WIDTH-1:0] final_len;       // AXI len of the last burst
    logic [STRB_WIDTH-1:0]      final_strb;
    logic                       single_txn;
  } burst_plan_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]      awaddr;
    logic [BURST_LEN_WIDTH-1:0] awlen;
  } aw_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wlast;
  } w_beat_t;

endpackage

`default_nettype wire

// ==== design/axi_write_master.sv ====
// AXI4 write master top, stream words in through a FIFO and out as incrementing bursts
`timescale 1ns/1ps
`default_nettype none

module axi_write_master #(
  parameter int MAX_OUTSTANDING = 4,
  parameter int FIFO_DEPTH      = 16
) (
  input  logic                                   aclk,
  input  logic                                   areset,
  // Control
  input  logic                                   ctrl_start,
  input  logic [axi_wm_pkg::ADDR_WIDTH-1:0]      ctrl_addr_offset,
  input  logic [axi_wm_pkg::XFER_SIZE_WIDTH-1:0] ctrl_xfer_size,
  output logic                                   ctrl_done,
  // Stream input
  input  logic                                   s_axis_tvalid,
  output logic                                   s_axis_tready,
  input  logic [axi_wm_pkg::DATA_WIDTH-1:0]      s_axis_tdata,
  // AXI4 write channels
  output axi_wm_pkg::aw_req_t                    m_axi_aw,
  output logic                                   m_axi_awvalid,
  input  logic                                   m_axi_awready,
  output axi_wm_pkg::w_beat_t                    m_axi_w,
  output logic                                   m_axi_wvalid,
  input  logic                                   m_axi_wready,
  input  logic                                   m_axi_bvalid,
  output logic                                   m_axi_bready
);
  import axi_wm_pkg::*;

  logic [DATA_WIDTH-1:0] fifo_data;
  logic                  fifo_valid;
  logic                  fifo_rd;
  logic                  start;
  burst_plan_t           plan;
  logic                  first_beat_pulse;
  logic                  aw_accepted;
  logic                  stall_aw;

  wstream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_wstream_fifo (
    .aclk(aclk), .areset(areset),
    .wr_valid(s_axis_tvalid), .wr_data(s_axis_tdata), .wr_ready(s_axis_tready),
    .rd_en(fifo_rd), .rd_data(fifo_data), .rd_valid(fifo_valid)
  );

  burst_planner u_burst_planner (
    .aclk(aclk), .ctrl_start(ctrl_start), .ctrl_addr_offset(ctrl_addr_offset),
    .ctrl_xfer_size(ctrl_xfer_size), .start(start), .plan(plan)
  );

  // Final beat marker stays local to the W channel
  wdata_channel u_wdata_channel (
    .aclk(aclk), .areset(areset), .start(start), .plan(plan),
    .fifo_data(fifo_data), .fifo_valid(fifo_valid), .fifo_rd(fifo_rd),
    .m_axi_w(m_axi_w), .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
    .first_beat_pulse(first_beat_pulse), .w_done()
  );

  awaddr_channel #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_awaddr_channel (
    .aclk(aclk), .areset(areset), .start(start), .plan(plan),
    .first_beat_pulse(first_beat_pulse), .stall_aw(stall_aw),
    .m_axi_aw(m_axi_aw), .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
    .aw_accepted(aw_accepted)
  );

  bresp_tracker #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_bresp_tracker (
    .aclk(aclk), .areset(areset), .start(start), .plan(plan),
    .aw_accepted(aw_accepted), .m_axi_bvalid(m_axi_bvalid), .m_axi_bready(m_axi_bready),
    .stall_aw(stall_aw), .ctrl_done(ctrl_done)
  );

endmodule

`default_nettype wire

// ==== design/bresp_tracker.sv ====
// Write response tracker, caps outstanding bursts and pulses done after the last response
`timescale 1ns/1ps
`default_nettype none

module bresp_tracker #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    start,
  input  axi_wm_pkg::burst_plan_t plan,
  input  logic                    aw_accepted,
  input  logic                    m_axi_bvalid,
  output logic                    m_axi_bready,
  output logic                    stall_aw,
  output logic                    ctrl_done
);
  import axi_wm_pkg::*;

  localparam int VAC_WIDTH = $clog2(MAX_OUTSTANDING + 1);

  logic                     bxfer;
  logic [VAC_WIDTH-1:0]     vacancy;   // Free slots for bursts awaiting B
  logic [TXN_CNT_WIDTH-1:0] b_to_go;

  // Responses are always taken
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;
  assign stall_aw     = (vacancy == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy   <= VAC_WIDTH'(MAX_OUTSTANDING);
      b_to_go   <= '0;
      ctrl_done <= 1'b0;
    end else begin
      if (aw_accepted && !bxfer) begin
        vacancy <= vacancy - 1'b1;
      end else if (bxfer && !aw_accepted) begin
        vacancy <= vacancy + 1'b1;
      end
      if (start) begin
        b_to_go <= plan.last_txn_index;
      end else if (bxfer) begin
        b_to_go <= b_to_go - 1'b1;
      end
      // One cycle after the final handshake
      ctrl_done <= bxfer & (b_to_go == '0);
    end
  end

  // No AW slips through with every slot taken
  a_aw_needs_slot: assert property (@(posedge aclk) disable iff (areset)
    aw_accepted |-> !stall_aw);

  a_vacancy_bound: assert property (@(posedge aclk) disable iff (areset)
    vacancy <= VAC_WIDTH'(MAX_OUTSTANDING));

endmodule

`default_nettype wire

// ==== design/burst_planner.sv ====
// Burst planner, turns a start command into base address, burst count and final burst shape
`timescale 1ns/1ps
`default_nettype none

module burst_planner (
  input  logic                                   aclk,
  input  logic                                   ctrl_start,
  input  logic [axi_wm_pkg::ADDR_WIDTH-1:0]      ctrl_addr_offset,
  input  logic [axi_wm_pkg::XFER_SIZE_WIDTH-1:0] ctrl_xfer_size,
  output logic                                   start,
  output axi_wm_pkg::burst_plan_t                plan
);
  import axi_wm_pkg::*;

  localparam int LOG_STRB    = $clog2(STRB_WIDTH);
  // One spare bit, a size just under 64 KiB rounds up to 2**14 words
  localparam int WORDS_WIDTH = XFER_SIZE_WIDTH - LOG_STRB + 1;
  localparam int FULL_WIDTH  = WORDS_WIDTH - BURST_LEN_WIDTH;
  localparam logic [ADDR_WIDTH-1:0] ALIGN_MASK = ADDR_WIDTH'(BURST_BYTES - 1);

  // Stage 1
  logic                   start_d1;
  logic [ADDR_WIDTH-1:0]  base_r;
  logic [WORDS_WIDTH-1:0] words_r;
  logic [LOG_STRB-1:0]    byte_rem_r;

  // Stage 2 inputs
  logic [FULL_WIDTH-1:0]  full_bursts;
  logic                   has_partial;
  logic [FULL_WIDTH-1:0]  last_idx;
  burst_plan_t            plan_next;

  ////////////////////////////////////////////////////////////
  // Stage 1 samples the command
  ////////////////////////////////////////////////////////////
  // Start pipe and command capture
  always_ff @(posedge aclk) begin
    start_d1 <= ctrl_start;
    if (ctrl_start) begin
      // Round bytes up to whole words
      words_r    <= WORDS_WIDTH'(ctrl_xfer_size[XFER_SIZE_WIDTH-1:LOG_STRB])
                    + WORDS_WIDTH'(|ctrl_xfer_size[LOG_STRB-1:0]);
      // Align down so no burst crosses a 1 KiB boundary
      base_r     <= ctrl_addr_offset & ~ALIGN_MASK;
      byte_rem_r <= ctrl_xfer_size[LOG_STRB-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 splits the word count into bursts
  ////////////////////////////////////////////////////////////
  assign full_bursts = words_r[WORDS_WIDTH-1:BURST_LEN_WIDTH];
  assign has_partial = |words_r[BURST_LEN_WIDTH-1:0];
  // Partial burst adds one to the full bursts, so no minus one for it
  assign last_idx    = has_partial ? full_bursts : full_bursts - 1'b1;

  always_comb begin
    plan_next.base_addr      = base_r;
    plan_next.last_txn_index = TXN_CNT_WIDTH'(last_idx);
    // Zero leftover words wraps to 255, a full last burst
    plan_next.final_len      = words_r[BURST_LEN_WIDTH-1:0] - 1'b1;
    plan_next.single_txn     = (last_idx == '0);
    // Lowest leftover bytes on the final beat, all of them for a whole word
    for (int i = 0; i < STRB_WIDTH; i++) begin
      plan_next.final_strb[i] = (byte_rem_r == '0) || (i < int'(byte_rem_r));
    end
  end

  always_ff @(posedge aclk) begin
    start <= start_d1;
    plan  <= plan_next;
  end

endmodule

`default_nettype wire

// ==== design/wdata_channel.sv ====
// AXI4 write data channel, paces FIFO words into bursts with WLAST and the final strobe
`timescale 1ns/1ps
`default_nettype none

module wdata_channel (
  input  logic                              aclk,
  input  logic                              areset,
  input  logic                              start,
  input  axi_wm_pkg::burst_plan_t           plan,
  input  logic [axi_wm_pkg::DATA_WIDTH-1:0] fifo_data,
  input  logic                              fifo_valid,
  output logic                              fifo_rd,
  output axi_wm_pkg::w_beat_t               m_axi_w,
  output logic                              m_axi_wvalid,
  input  logic                              m_axi_wready,
  output logic                              first_beat_pulse,
  output logic                              w_done
);
  import axi_wm_pkg::*;

  localparam logic [BURST_LEN_WIDTH-1:0] FULL_LEN = BURST_LEN_WIDTH'(BURST_LEN - 1);

  logic                       running;
  logic                       wxfer;
  logic                       wlast;
  logic                       final_txn;
  logic [BURST_LEN_WIDTH-1:0] beats_to_go;
  logic [TXN_CNT_WIDTH-1:0]   bursts_to_go;
  logic                       wfirst;   // Next valid beat opens a burst not yet announced

  // Beats only flow once the transfer shape is known
  assign m_axi_wvalid  = fifo_valid & running;
  assign wxfer         = m_axi_wvalid & m_axi_wready;
  assign fifo_rd       = wxfer;

  assign wlast         = (beats_to_go == '0);
  assign final_txn     = (bursts_to_go == '0);
  assign w_done        = wxfer & wlast & final_txn;

  assign m_axi_w.wdata = fifo_data;
  assign m_axi_w.wlast = wlast;
  // Partial strobe on the very last beat only
  assign m_axi_w.wstrb = (wlast && final_txn) ? plan.final_strb : '1;

  ////////////////////////////////////////////////////////////
  // Run flag and beat counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      running      <= 1'b0;
      beats_to_go  <= FULL_LEN;
      bursts_to_go <= '0;
    end else if (start) begin
      running      <= 1'b1;
      beats_to_go  <= plan.single_txn ? plan.final_len : FULL_LEN;
      bursts_to_go <= plan.last_txn_index;
    end else if (wxfer) begin
      if (wlast) begin
        bursts_to_go <= bursts_to_go - 1'b1;
        // Next burst is the last one, it takes the short length
        beats_to_go  <= (bursts_to_go == TXN_CNT_WIDTH'(1)) ? plan.final_len : FULL_LEN;
      end else begin
        beats_to_go <= beats_to_go - 1'b1;
      end
      if (w_done) begin
        running <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // First beat detect for the address channel
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst           <= 1'b1;
      first_beat_pulse <= 1'b0;
    end else begin
      first_beat_pulse <= m_axi_wvalid & wfirst;
      if (wxfer && wlast) begin
        wfirst <= 1'b1;
      end else if (m_axi_wvalid) begin
        wfirst <= 1'b0;
      end
    end
  end

  // Stalled beat keeps its data, strobe and last flag
  a_w_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_w));

endmodule

`default_nettype wire

// ==== design/wstream_fifo.sv ====
// Stream word FIFO, synchronous with first-word-fall-through read ahead of the W channel
`timescale 1ns/1ps
`default_nettype none

module wstream_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                              aclk,
  input  logic                              areset,
  input  logic                              wr_valid,
  input  logic [axi_wm_pkg::DATA_WIDTH-1:0] wr_data,
  output logic                              wr_ready,
  input  logic                              rd_en,
  output logic [axi_wm_pkg::DATA_WIDTH-1:0] rd_data,
  output logic                              rd_valid
);
  import axi_wm_pkg::*;

  // Pointers wrap on their own, so depth is a power of two
  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [CNT_WIDTH-1:0]  count;
  logic [CNT_WIDTH-1:0]  count_next;
  logic                  wr_en;

  assign wr_en    = wr_valid & wr_ready;
  assign rd_valid = (count != '0);
  // Oldest word shows straight from the array
  assign rd_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (wr_en && !rd_en) begin
      count_next = count + 1'b1;
    end else if (rd_en && !wr_en) begin
      count_next = count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers, fill level and registered ready
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      wr_ready <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count    <= count_next;
      // Ready drops one cycle ahead, the moment the last slot fills
      wr_ready <= (count_next != CNT_WIDTH'(FIFO_DEPTH));
    end
  end

  a_no_write_full: assert property (@(posedge aclk) disable iff (areset)
    wr_en |-> count < CNT_WIDTH'(FIFO_DEPTH));

  a_no_read_empty: assert property (@(posedge aclk) disable iff (areset)
    rd_en |-> rd_valid);

endmodule

`default_nettype wire

// ==== tb/axi_write_tests.txt ====
# Columns: start address (hex), transfer size in bytes (decimal), random back-pressure (0 or 1)
# Sizes start at one byte, back-pressure also delays the write responses
00000000 4 0
00000100 1 0
12345678 7 0
00000400 1024 0
00000404 1030 0
0000abcd 2 1
0000ffff 4096 1
10000000 6000 1
20000abc 8191 1
000003ff 3 1
40000000 2050 0
3ffff800 5123 1
00c0ffee 1021 1
7ffffc00 1028 0
55555555 4097 1

// ==== tb/tb_axi_write_master.sv ====
// Testbench for the AXI4 write master with stream source, AXI slave model and scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_master;
  import axi_wm_pkg::*;

  localparam int MAX_OUTSTANDING = 4;
  localparam int WINDOW_BYTES    = 1024;  // Address step per burst
  localparam int WORDS_PER_BURST = 256;
  localparam int WAIT_LIMIT      = 50000;
  localparam int IDLE_CYCLES     = 16;

  logic                       aclk = 1'b0;
  logic                       areset;
  logic                       ctrl_start;
  logic [ADDR_WIDTH-1:0]      ctrl_addr_offset;
  logic [XFER_SIZE_WIDTH-1:0] ctrl_xfer_size;
  logic                       ctrl_done;
  logic                       s_axis_tvalid;
  logic                       s_axis_tready;
  logic [DATA_WIDTH-1:0]      s_axis_tdata;
  aw_req_t                    m_axi_aw;
  logic                       m_axi_awvalid;
  logic                       m_axi_awready;
  w_beat_t                    m_axi_w;
  logic                       m_axi_wvalid;
  logic                       m_axi_wready;
  logic                       m_axi_bvalid;
  logic                       m_axi_bready;

  integer seed      = 32'h3de7_0c1b;
  int     errors    = 0;
  int     checks    = 0;
  int     tests_run = 0;
  bit     timed_out = 1'b0;

  // Current test, only changed while the DUT is idle
  int                    test_no = 0;
  logic [ADDR_WIDTH-1:0] exp_base = '0;
  int                    exp_size = 0;
  int                    exp_words = 0;
  int                    exp_bursts = 0;
  bit                    backpressure = 1'b0;

  // Scoreboard counts of the current test
  int aw_seen = 0;
  int w_seen = 0;
  int b_seen = 0;
  int done_seen = 0;
  int cycle = 0;
  int last_b_cycle = -10;

  // Slave model totals over the whole run
  int slv_aw = 0;
  int slv_wlast = 0;
  int slv_b = 0;
  // Burst total on W that releases the held responses of the current test
  int resp_gate_wlast = 0;

  always #4 aclk = ~aclk;

  axi_write_master #(.MAX_OUTSTANDING(MAX_OUTSTANDING), .FIFO_DEPTH(16)) u_axi_write_master (
    .aclk(aclk), .areset(areset),
    .ctrl_start(ctrl_start), .ctrl_addr_offset(ctrl_addr_offset),
    .ctrl_xfer_size(ctrl_xfer_size), .ctrl_done(ctrl_done),
    .s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready), .s_axis_tdata(s_axis_tdata),
    .m_axi_aw(m_axi_aw), .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
    .m_axi_w(m_axi_w), .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
    .m_axi_bvalid(m_axi_bvalid), .m_axi_bready(m_axi_bready)
  );

  task automatic report_mismatch(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // AXI slave model
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    if (areset) begin
      m_axi_awready <= 1'b0;
      m_axi_wready  <= 1'b0;
      m_axi_bvalid  <= 1'b0;
    end else begin
      if (m_axi_awvalid && m_axi_awready) begin
        slv_aw = slv_aw + 1;
      end
      if (m_axi_wvalid && m_axi_wready && m_axi_w.wlast) begin
        slv_wlast = slv_wlast + 1;
      end
      if (m_axi_bvalid && m_axi_bready) begin
        slv_b = slv_b + 1;
      end
      m_axi_awready <= !backpressure || (($random(seed) & 1) == 1);
      m_axi_wready  <= !backpressure || (($random(seed) & 1) == 1);
      // A response needs both the address and the last beat of its burst
      // Under back-pressure responses wait for the whole transfer on W
      if (m_axi_bvalid && !m_axi_bready) begin
        m_axi_bvalid <= 1'b1;
      end else if (slv_b < slv_aw && slv_b < slv_wlast &&
                   (!backpressure || slv_wlast >= resp_gate_wlast)) begin
        m_axi_bvalid <= !backpressure || (($random(seed) & 7) == 0);
      end else begin
        m_axi_bvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////
  task automatic check_aw_request();
    logic [ADDR_WIDTH-1:0] addr;
    int                    len;
    addr = exp_base + ADDR_WIDTH'(aw_seen * WINDOW_BYTES);
    // Only the last burst is short
    len  = (aw_seen == exp_bursts - 1) ?
           exp_words - WORDS_PER_BURST * (exp_bursts - 1) - 1 : WORDS_PER_BURST - 1;
    checks++;
    if (aw_seen >= exp_bursts) begin
      report_mismatch($sformatf("test %0d extra AW at 0x%08h", test_no, m_axi_aw.awaddr));
    end else if (m_axi_aw.awaddr !== addr || m_axi_aw.awlen !== BURST_LEN_WIDTH'(len)) begin
      report_mismatch($sformatf("test %0d AW %0d got 0x%08h len %0d, expected 0x%08h len %0d",
        test_no, aw_seen, m_axi_aw.awaddr, m_axi_aw.awlen, addr, len));
    end
    aw_seen++;
  endtask

  task automatic check_w_beat();
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
    data = DATA_WIDTH'(test_no * 65536 + w_seen);
    last = ((w_seen % WORDS_PER_BURST) == WORDS_PER_BURST - 1) || (w_seen == exp_words - 1);
    strb = '1;
    // Partial strobe covers the lowest leftover bytes
    if (w_seen == exp_words - 1 && (exp_size % 4) != 0) begin
      strb = STRB_WIDTH'((1 << (exp_size % 4)) - 1);
    end
    checks++;
    if (w_seen >= exp_words) begin
      report_mismatch($sformatf("test %0d extra W beat 0x%08h", test_no, m_axi_w.wdata));
    end else if (m_axi_w.wdata !== data || m_axi_w.wstrb !== strb || m_axi_w.wlast !== last) begin
      report_mismatch($sformatf("test %0d beat %0d got %08h/%h/%b, expected %08h/%h/%b",
        test_no, w_seen, m_axi_w.wdata, m_axi_w.wstrb, m_axi_w.wlast, data, strb, last));
    end
    w_seen++;
  endtask

  always @(posedge aclk) begin
    if (!areset) begin
      cycle = cycle + 1;
      // Done must follow the final response by exactly one cycle
      if (ctrl_done) begin
        done_seen++;
        checks++;
        if (b_seen != exp_bursts || cycle != last_b_cycle + 1) begin
          report_mismatch($sformatf("test %0d ctrl_done not one cycle after the final B",
            test_no));
        end
      end
      if (m_axi_awvalid && m_axi_awready) begin
        check_aw_request();
      end
      if (m_axi_wvalid && m_axi_wready) begin
        check_w_beat();
      end
      // Every response is taken at once
      if (m_axi_bready !== 1'b1) begin
        report_mismatch($sformatf("test %0d bready is %b, expected 1", test_no, m_axi_bready));
      end
      if (m_axi_bvalid && m_axi_bready) begin
        b_seen++;
        checks++;
        if (b_seen > exp_bursts) begin
          report_mismatch($sformatf("test %0d extra B response", test_no));
        end
        if (b_seen == exp_bursts) begin
          last_b_cycle = cycle;
        end
      end
      if (aw_seen - b_seen > MAX_OUTSTANDING) begin
        report_mismatch($sformatf("test %0d has %0d bursts outstanding", test_no,
          aw_seen - b_seen));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stream source and waits
  ////////////////////////////////////////////////////////////
  task automatic send_stream(input int words);
    int idx;
    int waited;
    bit moved;
    idx    = 0;
    waited = 0;
    while (idx < words && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
      moved = s_axis_tvalid && s_axis_tready;
      if (moved) begin
        idx++;
      end
      // Valid holds until the word is taken
      if (moved || !s_axis_tvalid) begin
        if (idx < words && (!backpressure || ($random(seed) & 1) == 1)) begin
          s_axis_tvalid <= 1'b1;
          s_axis_tdata  <= DATA_WIDTH'(test_no * 65536 + idx);
        end else begin
          s_axis_tvalid <= 1'b0;
        end
      end
    end
    if (idx < words) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: stream source of test %0d sent only %0d of %0d words",
        test_no, idx, words);
    end
  endtask

  task automatic wait_for_done();
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      waited++;
      seen = ctrl_done;
    end
    if (!seen) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: no ctrl_done in test %0d within %0d cycles", test_no, WAIT_LIMIT);
    end
  endtask

  task automatic run_test(input logic [ADDR_WIDTH-1:0] addr, input int size, input bit bp);
    test_no      = test_no + 1;
    tests_run++;
    exp_base     = addr & 32'hffff_fc00;
    exp_size     = size;
    exp_words    = (size + 3) / 4;
    exp_bursts   = (exp_words + WORDS_PER_BURST - 1) / WORDS_PER_BURST;
    backpressure = bp;
    resp_gate_wlast = slv_wlast + exp_bursts;
    aw_seen      = 0;
    w_seen       = 0;
    b_seen       = 0;
    done_seen    = 0;
    last_b_cycle = -10;
    @(posedge aclk);
    ctrl_start       <= 1'b1;
    ctrl_addr_offset <= addr;
    ctrl_xfer_size   <= XFER_SIZE_WIDTH'(size);
    @(posedge aclk);
    ctrl_start <= 1'b0;
    fork
      send_stream(exp_words);
      wait_for_done();
    join
    // Quiet period catches late or repeated pulses
    repeat (IDLE_CYCLES) @(posedge aclk);
    checks++;
    if (done_seen != 1 || aw_seen != exp_bursts || w_seen != exp_words ||
        b_seen != exp_bursts) begin
      report_mismatch($sformatf(
        "test %0d counts done %0d aw %0d w %0d b %0d, expected 1 %0d %0d %0d",
        test_no, done_seen, aw_seen, w_seen, b_seen, exp_bursts, exp_words, exp_bursts));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int                    fd;
    int                    code;
    logic [ADDR_WIDTH-1:0] addr;
    int                    size;
    int                    bp;
    logic [8*256-1:0]      skip_line;
    areset           = 1'b1;
    ctrl_start       = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size   = '0;
    s_axis_tvalid    = 1'b0;
    s_axis_tdata     = '0;
    m_axi_awready    = 1'b0;
    m_axi_wready     = 1'b0;
    m_axi_bvalid     = 1'b0;
    repeat (5) @(posedge aclk);
    areset <= 1'b0;
    fd = $fopen("tb/axi_write_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the test file tb/axi_write_tests.txt");
    end else begin
      while (!$feof(fd) && !timed_out) begin
        code = $fscanf(fd, " %h %d %d", addr, size, bp);
        if (code == 3) begin
          run_test(addr, size, bp != 0);
        end else begin
          // Comment line, drop the rest of it
          code = $fgets(skip_line, fd);
        end
      end
      $fclose(fd);
    end
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/axi_wm_pkg.sv
design/wstream_fifo.sv
design/burst_planner.sv
design/wdata_channel.sv
design/awaddr_channel.sv
design/bresp_tracker.sv
design/axi_write_master.sv
tb/tb_axi_write_master.sv
